// File: eth_tx_subsystem.f
source/eth_pkg.sv
source/eth_crc32_byte.sv
source/eth_mac_tx.sv
source/tx_queue_fifo.sv
source/tx_frame_dispatch.sv
source/tx_queue_arbiter.sv
source/eth_tx_subsystem.sv
tb/eth_tx_subsystem_sva.sv
tb/tb_eth_tx_subsystem.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_eth_tx_subsystem
FILELIST  := eth_tx_subsystem.f
OBJ_DIR   := obj_dir
PASS_TEXT := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_eth_tx_subsystem.sv
// testbench for the multi-queue GMII transmit path
// the host model pushes each frame onto its queue's expected list, and the
// GMII monitor pops the list named by the queue byte of each burst
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx_subsystem;

    localparam int NUM_QUEUES       = 4;
    localparam int QUEUE_DEPTH      = 64;
    localparam int MIN_FRAME_LENGTH = 64;
    localparam int MIN_DATA         = MIN_FRAME_LENGTH - 4;
    localparam int QW               = $clog2(NUM_QUEUES);
    localparam int NUM_RANDOM       = 20;
    localparam int NUM_ROUNDS       = 3;
    localparam int IFG_SHORT        = 12;
    localparam int IFG_LONG         = 20;
    localparam int LEAD_LEN         = 40;

    // expected frame, kept per queue in send order
    typedef struct packed {
        logic [7:0] seq;
        logic [7:0] len;
        logic       bad;
        logic       rot;
    } exp_frame_t;

    logic                  clk;
    logic                  reset_crc;
    eth_pkg::tx_beat_t     host_beat;
    logic                  host_valid;
    logic [QW-1:0]         host_queue;
    logic [NUM_QUEUES-1:0] credit_return;
    logic [7:0]            ifg_delay;
    eth_pkg::gmii_tx_t     gmii;

    int seed;
    int cycles      = 0;
    int cycle_limit = 0;
    int err_frame   = 0;
    int err_host    = 0;
    int err_er      = 0;
    int err_reset   = 0;
    int frames_sent;
    int frames_seen;
    int spent    [NUM_QUEUES];
    int returned [NUM_QUEUES];
    int seq_in   [NUM_QUEUES];
    int rand_len [NUM_RANDOM];
    int rand_q   [NUM_RANDOM];
    bit rand_bad [NUM_RANDOM];

    exp_frame_t expected [NUM_QUEUES][$];

    // GMII monitor state
    logic [7:0] burst [$];
    logic       burst_er [$];
    logic       in_burst;
    int         gap;
    int         prev_q;
    bit         prev_rot;

    eth_tx_subsystem #(
        .NUM_QUEUES      (NUM_QUEUES),
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .ENABLE_PADDING  (1),
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH)
    ) u_eth_tx_subsystem (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .host_beat    (host_beat),
        .host_valid   (host_valid),
        .host_queue   (host_queue),
        .credit_return(credit_return),
        .ifg_delay    (ifg_delay),
        .gmii         (gmii)
    );

    always #5 clk = ~clk;

    // byte i of a frame: queue, sequence, length, flags, then a fill pattern
    function automatic logic [7:0] frame_byte(input int q, input int seq, input int len,
                                               input bit bad, input bit rot, input int i);
        logic [7:0] b;
        case (i)
            0:       b = 8'(q);
            1:       b = 8'(seq);
            2:       b = 8'(len);
            3:       b = {bad, rot, 6'b0};
            default: b = 8'(q * 37 + seq * 11 + i * 5 + 3);
        endcase
        return b;
    endfunction

    // reference CRC, one data bit at a time, lsb first
    function automatic logic [31:0] crc_of_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            if (c[0] ^ d[k]) begin
                c = (c >> 1) ^ eth_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    function automatic int wire_cycles(input int len);
        return 8 + ((len < MIN_DATA) ? MIN_DATA : len) + 4 + IFG_LONG;
    endfunction

    function automatic int credits_free(input int q);
        return QUEUE_DEPTH - spent[q] + returned[q];
    endfunction

    task automatic check_byte(input string name, input int idx, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s byte %0d: got 0x%02h, expected 0x%02h", name, idx, got, exp);
            err_frame++;
        end
    endtask

    task automatic check_frame();
        int          q;
        int          seq;
        int          len;
        int          data_len;
        int          exp_size;
        bit          bad;
        bit          rot;
        exp_frame_t  entry;
        logic [7:0]  exp;
        logic [31:0] crc;
        frames_seen++;
        if (burst.size() < 12) begin
            $display("burst %0d is too short to hold a frame header", frames_seen);
            err_frame++;
            return;
        end
        for (int i = 0; i < 7; i++) begin
            check_byte("gmii.txd preamble", i, burst[i], eth_pkg::PREAMBLE_BYTE);
        end
        check_byte("gmii.txd sfd", 7, burst[7], eth_pkg::SFD_BYTE);
        q = int'(burst[8]);
        if (q >= NUM_QUEUES) begin
            $display("burst %0d names queue %0d, which does not exist", frames_seen, q);
            err_frame++;
            return;
        end
        if (expected[q].size() == 0) begin
            $display("burst %0d comes from queue %0d, which has no frame pending",
                     frames_seen, q);
            err_frame++;
            return;
        end
        entry = expected[q].pop_front();
        seq   = int'(entry.seq);
        len   = int'(entry.len);
        bad   = entry.bad;
        rot   = entry.rot;
        check_byte("gmii.txd sequence", 9, burst[9], entry.seq);
        if (rot && prev_rot) begin
            check_byte("gmii.txd queue", 8, burst[8], 8'((prev_q + 1) % NUM_QUEUES));
        end
        prev_q   = q;
        prev_rot = rot;
        data_len = (bad || len >= MIN_DATA) ? len : MIN_DATA;
        exp_size = bad ? 8 + len + 1 : 8 + data_len + 4;
        if (burst.size() != exp_size) begin
            $display("Mismatch burst length: got 0x%0h, expected 0x%0h", burst.size(), exp_size);
            err_frame++;
            return;
        end
        crc = eth_pkg::CRC_INIT;
        for (int i = 0; i < data_len; i++) begin
            exp = (i < len) ? frame_byte(q, seq, len, bad, rot, i) : 8'h00;
            check_byte("gmii.txd data", i, burst[8 + i], exp);
            crc = crc_of_byte(crc, exp);
        end
        if (!bad) begin
            for (int k = 0; k < 4; k++) begin
                check_byte("gmii.txd fcs", k, burst[8 + data_len + k], ~crc[8 * k +: 8]);
            end
        end
        // tx_er only on the byte after the data of a flagged frame
        for (int i = 0; i < exp_size; i++) begin
            check_byte("gmii.tx_er", i, 8'(burst_er[i]), 8'(bad && i == exp_size - 1));
        end
    endtask

    task automatic send_frame(input int q, input int len, input bit bad, input bit rot);
        int         seq;
        exp_frame_t entry;
        seq       = seq_in[q];
        entry.seq = 8'(seq);
        entry.len = 8'(len);
        entry.bad = bad;
        entry.rot = rot;
        expected[q].push_back(entry);
        while (credits_free(q) < len) begin
            @(negedge clk);
        end
        for (int i = 0; i < len; i++) begin
            host_valid     = 1'b1;
            host_queue     = QW'(q);
            host_beat.data = frame_byte(q, seq, len, bad, rot, i);
            host_beat.last = (i == len - 1);
            host_beat.user = bad && (i == len - 1);
            spent[q]++;
            @(negedge clk);
        end
        host_valid = 1'b0;
        host_beat  = '0;
        seq_in[q]++;
        frames_sent++;
    endtask

    task automatic drain();
        while (frames_seen < frames_sent) begin
            @(negedge clk);
        end
        repeat (IFG_LONG + 10) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (reset_crc) begin
            in_burst    = 1'b0;
            gap         = 0;
            frames_seen = 0;
            prev_q      = 0;
            prev_rot    = 1'b0;
            burst.delete();
            burst_er.delete();
        end else if (gmii.tx_en) begin
            if (!in_burst && frames_seen > 0) begin
                assert (gap >= int'(ifg_delay)) else begin
                    $display("Mismatch gap before burst: got 0x%0h, expected at least 0x%0h",
                             gap, ifg_delay);
                    err_frame++;
                end
            end
            if (!in_burst) begin
                burst.delete();
                burst_er.delete();
            end
            in_burst = 1'b1;
            burst.push_back(gmii.txd);
            burst_er.push_back(gmii.tx_er);
        end else begin
            if (in_burst) begin
                check_frame();
                gap = 0;
            end
            in_burst = 1'b0;
            gap++;
        end
    end

    always @(posedge clk) begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (reset_crc) begin
                returned[q] = 0;
            end else if (credit_return[q]) begin
                returned[q]++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    er_inside_burst: assert property (@(posedge clk) disable iff (reset_crc)
                                      gmii.tx_er |-> gmii.tx_en)
        else begin
            $display("tx_er went high while tx_en was low");
            err_er++;
        end

    quiet_after_reset: assert property (@(posedge clk)
                                        reset_crc |=> (credit_return == '0 && !gmii.tx_en))
        else begin
            $display("credit_return or tx_en was active in the cycle after reset");
            err_reset++;
        end

    initial begin
        int total;
        clk         = 1'b0;
        reset_crc   = 1'b1;
        host_valid  = 1'b0;
        host_beat   = '0;
        host_queue  = '0;
        ifg_delay   = 8'(IFG_SHORT);
        frames_sent = 0;
        seed        = 32'ha4e9_8ce5;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            spent[q]  = 0;
            seq_in[q] = 0;
        end
        total = wire_cycles(MIN_DATA - 1) + wire_cycles(MIN_DATA) + wire_cycles(MIN_DATA + 1);
        total = total + wire_cycles(20) + wire_cycles(LEAD_LEN);
        total = total + (NUM_ROUNDS * NUM_QUEUES - 1) * wire_cycles(8);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_len[i] = 4 + int'($unsigned($random(seed)) % 61);
            rand_q[i]   = int'($unsigned($random(seed)) % NUM_QUEUES);
            rand_bad[i] = ($unsigned($random(seed)) % 6) == 0;
            total       = total + wire_cycles(rand_len[i]);
        end
        cycle_limit = 2 * (total + 16 + 2 * (IFG_LONG + 10));

        repeat (16) begin
            @(negedge clk);
        end
        reset_crc = 1'b0;

        // padding boundary, then a flagged frame
        send_frame(0, MIN_DATA - 1, 1'b0, 1'b0);
        send_frame(1, MIN_DATA, 1'b0, 1'b0);
        send_frame(2, MIN_DATA + 1, 1'b0, 1'b0);
        send_frame(3, 20, 1'b1, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_frame(rand_q[i], rand_len[i], rand_bad[i], 1'b0);
        end
        drain();

        // all queues backlogged, written in reverse order
        // a long lead frame lets the other queues fill before the next grant
        ifg_delay = 8'(IFG_LONG);
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
                send_frame(q, (r == 0 && q == NUM_QUEUES - 1) ? LEAD_LEN : 8, 1'b0, 1'b1);
            end
        end
        drain();

        for (int q = 0; q < NUM_QUEUES; q++) begin
            assert (returned[q] == spent[q]) else begin
                $display("Mismatch credit_return count q%0d: got 0x%0h, expected 0x%0h",
                         q, returned[q], spent[q]);
                err_host++;
            end
            assert (expected[q].size() == 0) else begin
                $display("queue %0d still has %0d frames that never came out",
                         q, expected[q].size());
                err_host++;
            end
        end

        $display("errors: frame %0d, host %0d, tx_er %0d, reset %0d (%0d frames)",
                 err_frame, err_host, err_er, err_reset, frames_seen);
        if (err_frame + err_host + err_er + err_reset == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/eth_tx_subsystem_sva.sv
// queue protocol checks, bound into every tx_queue_fifo instance
// taps the fifo's internal full and empty flags
`timescale 1ns/1ns
`default_nettype none

module eth_tx_subsystem_sva (
    input wire logic clk,
    input wire logic reset_crc,
    input wire logic wr_en,
    input wire logic pop,
    input wire logic full,
    input wire logic empty,
    input wire logic credit
);

    // host credits must keep writes away from a full queue
    property no_write_when_full;
        @(posedge clk) disable iff (reset_crc) wr_en |-> !full;
    endproperty

    // arbiter only grants queues holding a whole frame
    property no_pop_when_empty;
        @(posedge clk) disable iff (reset_crc) pop |-> !empty;
    endproperty

    property credit_quiet_after_reset;
        @(posedge clk) reset_crc |=> !credit;
    endproperty

    write_not_full: assert property (no_write_when_full)
        else $error("queue written while full");
    pop_not_empty: assert property (no_pop_when_empty)
        else $error("queue popped while empty");
    credit_after_reset: assert property (credit_quiet_after_reset)
        else $error("credit pulse in the cycle after reset");

endmodule

bind tx_queue_fifo eth_tx_subsystem_sva u_queue_sva (
    .clk      (clk),
    .reset_crc(reset_crc),
    .wr_en    (wr_en),
    .pop      (pop),
    .full     (full),
    .empty    (empty),
    .credit   (credit)
);

`default_nettype wire

// File: source/eth_tx_subsystem.sv
// multi-queue GMII transmit path with credit-based host flow control
// host starts with QUEUE_DEPTH credits per queue and must not overrun them
// NUM_QUEUES must be at least 2
`timescale 1ns/1ns
`default_nettype none

module eth_tx_subsystem #(
    parameter int NUM_QUEUES       = 4,
    parameter int QUEUE_DEPTH      = 64,
    parameter int ENABLE_PADDING   = 1,
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  wire logic                          clk,
    input  wire logic                          reset_crc,
    input  wire eth_pkg::tx_beat_t             host_beat,
    input  wire logic                          host_valid,
    input  wire logic [$clog2(NUM_QUEUES)-1:0] host_queue,
    output logic [NUM_QUEUES-1:0]              credit_return,
    input  wire logic [7:0]                    ifg_delay,
    output eth_pkg::gmii_tx_t                  gmii
);

    eth_pkg::tx_beat_t                  q_beat;
    logic [NUM_QUEUES-1:0]              q_wr;
    eth_pkg::tx_beat_t [NUM_QUEUES-1:0] queue_head;
    logic [NUM_QUEUES-1:0]              frame_ready;
    logic [NUM_QUEUES-1:0]              queue_pop;
    eth_pkg::tx_beat_t                  tx_beat;
    logic                               tx_valid;
    logic                               tx_ready;

    tx_frame_dispatch #(
        .NUM_QUEUES(NUM_QUEUES)
    ) u_dispatch (
        .clk       (clk),
        .reset_crc (reset_crc),
        .host_beat (host_beat),
        .host_valid(host_valid),
        .host_queue(host_queue),
        .q_beat    (q_beat),
        .q_wr      (q_wr)
    );

    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        tx_queue_fifo #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_fifo (
            .clk        (clk),
            .reset_crc  (reset_crc),
            .wr_beat    (q_beat),
            .wr_en      (q_wr[q]),
            .head       (queue_head[q]),
            .pop        (queue_pop[q]),
            .frame_ready(frame_ready[q]),
            .credit     (credit_return[q])
        );
    end

    tx_queue_arbiter #(
        .NUM_QUEUES(NUM_QUEUES)
    ) u_arbiter (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .head       (queue_head),
        .frame_ready(frame_ready),
        .pop        (queue_pop),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    eth_mac_tx #(
        .ENABLE_PADDING  (ENABLE_PADDING),
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH)
    ) u_mac (
        .clk      (clk),
        .reset_crc(reset_crc),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .gmii     (gmii),
        .ifg_delay(ifg_delay)
    );

endmodule

`default_nettype wire

// File: source/tx_queue_arbiter.sv
// frame-level round robin; a queue is granted only once it holds a whole frame,
// and the grant is held until that frame's last beat transfers
`timescale 1ns/1ns
`default_nettype none

module tx_queue_arbiter #(
    parameter int NUM_QUEUES = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 reset_crc,
    input  wire eth_pkg::tx_beat_t [NUM_QUEUES-1:0]   head,
    input  wire logic [NUM_QUEUES-1:0]                frame_ready,
    output logic [NUM_QUEUES-1:0]                     pop,
    output eth_pkg::tx_beat_t                         tx_beat,
    output logic                                      tx_valid,
    input  wire logic                                 tx_ready
);

    localparam int QW = $clog2(NUM_QUEUES);

    logic [QW-1:0] grant;
    logic [QW-1:0] last_winner;
    logic [QW-1:0] pick;
    logic          pick_valid;
    logic          busy;
    logic          transfer;

    // nearest ready queue after the last winner, scanning far to near
    always_comb begin
        int idx;
        pick       = last_winner;
        pick_valid = 1'b0;
        for (int i = NUM_QUEUES; i >= 1; i--) begin
            idx = (int'(last_winner) + i) % NUM_QUEUES;
            if (frame_ready[idx]) begin
                pick       = QW'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    assign tx_valid = busy;
    assign tx_beat  = head[grant];
    assign transfer = busy && tx_ready;

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            pop[q] = transfer && (grant == QW'(q));
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            busy        <= 1'b0;
            grant       <= '0;
            // queue 0 wins first
            last_winner <= QW'(NUM_QUEUES - 1);
        end else if (!busy) begin
            if (pick_valid) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (transfer && tx_beat.last) begin
            busy        <= 1'b0;
            last_winner <= grant;
        end
    end

endmodule

`default_nettype wire

// File: source/tx_frame_dispatch.sv
// steers host beats to the queue named on each frame's first beat
// one cycle from host beat to queue write; NUM_QUEUES must be at least 2
`timescale 1ns/1ns
`default_nettype none

module tx_frame_dispatch #(
    parameter int NUM_QUEUES = 4
) (
    input  wire logic                          clk,
    input  wire logic                          reset_crc,
    input  wire eth_pkg::tx_beat_t             host_beat,
    input  wire logic                          host_valid,
    input  wire logic [$clog2(NUM_QUEUES)-1:0] host_queue,
    output eth_pkg::tx_beat_t                  q_beat,
    output logic [NUM_QUEUES-1:0]              q_wr
);

    localparam int QW = $clog2(NUM_QUEUES);

    logic          first_beat;
    logic [QW-1:0] queue_latched;
    logic [QW-1:0] cur_queue;

    // host_queue only counts on the first beat of a frame
    assign cur_queue = first_beat ? host_queue : queue_latched;

    always_ff @(posedge clk) begin
        q_beat <= host_beat;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            first_beat    <= 1'b1;
            queue_latched <= '0;
            q_wr          <= '0;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                q_wr[q] <= host_valid && (cur_queue == QW'(q));
            end
            if (host_valid) begin
                first_beat    <= host_beat.last;
                queue_latched <= cur_queue;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tx_queue_fifo.sv
// one transmit queue; writes to a full queue and pops of an empty one are dropped
// credit pulses one cycle after each accepted pop
`timescale 1ns/1ns
`default_nettype none

module tx_queue_fifo #(
    parameter int QUEUE_DEPTH = 64
) (
    input  wire logic              clk,
    input  wire logic              reset_crc,
    input  wire eth_pkg::tx_beat_t wr_beat,
    input  wire logic              wr_en,
    output eth_pkg::tx_beat_t      head,
    input  wire logic              pop,
    output logic                   frame_ready,
    output logic                   credit
);

    localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    eth_pkg::tx_beat_t mem [QUEUE_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     fill_count;
    logic [CW-1:0]     frame_count;
    logic              full;
    logic              empty;
    logic              do_write;
    logic              do_pop;
    logic              frame_in;
    logic              frame_out;

    assign full        = (fill_count == CW'(QUEUE_DEPTH));
    assign empty       = (fill_count == '0);
    assign do_write    = wr_en && !full;
    assign do_pop      = pop && !empty;
    assign head        = mem[rd_ptr];
    assign frame_in    = do_write && wr_beat.last;
    assign frame_out   = do_pop && head.last;
    assign frame_ready = (frame_count != '0);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill_count  <= '0;
            frame_count <= '0;
            credit      <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill_count  <= fill_count + CW'(do_write) - CW'(do_pop);
            // whole frames held, counted on their last beat
            frame_count <= frame_count + CW'(frame_in) - CW'(frame_out);
            credit      <= do_pop;
        end
    end

endmodule

`default_nettype wire

// File: source/eth_mac_tx.sv
// GMII transmit MAC: preamble, SFD, zero padding, FCS and inter-frame gap
// tx_valid must stay high for the whole frame once payload starts; a gap
// inside a frame is not treated as underflow
`timescale 1ns/1ns
`default_nettype none

module eth_mac_tx #(
    parameter int ENABLE_PADDING   = 1,
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  wire logic              clk,
    input  wire logic              reset_crc,
    input  wire eth_pkg::tx_beat_t tx_beat,
    input  wire logic              tx_valid,
    output logic                   tx_ready,
    output eth_pkg::gmii_tx_t      gmii,
    input  wire logic [7:0]        ifg_delay
);

    // last pointer value that still needs a pad byte after it (60 data bytes total)
    localparam int PAD_LIMIT = MIN_FRAME_LENGTH - 5;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS,
        ST_IFG
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [15:0]       ptr_q;
    logic [15:0]       ptr_d;
    logic              bad_q;
    logic              bad_d;
    logic              tx_ready_q;
    logic              tx_ready_d;
    eth_pkg::gmii_tx_t gmii_q;
    eth_pkg::gmii_tx_t gmii_d;
    logic [31:0]       crc_q;
    logic [31:0]       crc_next;
    logic              crc_clear;
    logic              crc_update;

    assign tx_ready = tx_ready_q;
    assign gmii     = gmii_q;

    // CRC runs over the byte being registered onto GMII
    eth_crc32_byte u_crc (
        .data_in  (gmii_d.txd),
        .crc_state(crc_q),
        .crc_next (crc_next)
    );

    always_comb begin
        state_d    = state_q;
        ptr_d      = ptr_q;
        bad_d      = bad_q;
        tx_ready_d = 1'b0;
        gmii_d     = '0;
        crc_clear  = 1'b0;
        crc_update = 1'b0;

        case (state_q)
            ST_IDLE: begin
                crc_clear = 1'b1;
                if (tx_valid) begin
                    ptr_d        = 16'd1;
                    gmii_d.txd   = eth_pkg::PREAMBLE_BYTE;
                    gmii_d.tx_en = 1'b1;
                    state_d      = ST_PREAMBLE;
                end
            end
            ST_PREAMBLE: begin
                crc_clear    = 1'b1;
                ptr_d        = ptr_q + 16'd1;
                gmii_d.txd   = eth_pkg::PREAMBLE_BYTE;
                gmii_d.tx_en = 1'b1;
                // seventh preamble byte already out, send SFD
                if (ptr_q == 16'd7) begin
                    ptr_d      = '0;
                    gmii_d.txd = eth_pkg::SFD_BYTE;
                    tx_ready_d = 1'b1;
                    state_d    = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                tx_ready_d = 1'b1;
                if (tx_valid) begin
                    crc_update   = 1'b1;
                    ptr_d        = ptr_q + 16'd1;
                    gmii_d.txd   = tx_beat.data;
                    gmii_d.tx_en = 1'b1;
                    if (tx_beat.last) begin
                        tx_ready_d = 1'b0;
                        if (tx_beat.user) begin
                            // error byte follows in place of the FCS
                            bad_d   = 1'b1;
                            ptr_d   = '0;
                            state_d = ST_FCS;
                        end else if (ENABLE_PADDING != 0 && int'(ptr_q) < PAD_LIMIT) begin
                            state_d = ST_PAD;
                        end else begin
                            ptr_d   = '0;
                            state_d = ST_FCS;
                        end
                    end
                end
            end
            ST_PAD: begin
                crc_update   = 1'b1;
                ptr_d        = ptr_q + 16'd1;
                gmii_d.tx_en = 1'b1;
                if (int'(ptr_q) >= PAD_LIMIT) begin
                    ptr_d   = '0;
                    state_d = ST_FCS;
                end
            end
            ST_FCS: begin
                gmii_d.tx_en = 1'b1;
                ptr_d        = ptr_q + 16'd1;
                if (bad_q) begin
                    gmii_d.tx_er = 1'b1;
                    bad_d        = 1'b0;
                    ptr_d        = '0;
                    state_d      = ST_IFG;
                end else begin
                    // lsb first, inverted
                    gmii_d.txd = ~crc_q[8 * ptr_q[1:0] +: 8];
                    if (ptr_q == 16'd3) begin
                        ptr_d   = '0;
                        state_d = ST_IFG;
                    end
                end
            end
            ST_IFG: begin
                crc_clear = 1'b1;
                ptr_d     = ptr_q + 16'd1;
                if (ptr_q + 16'd1 >= {8'd0, ifg_delay}) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_q    <= ST_IDLE;
            ptr_q      <= '0;
            bad_q      <= 1'b0;
            tx_ready_q <= 1'b0;
            gmii_q     <= '0;
            crc_q      <= eth_pkg::CRC_INIT;
        end else begin
            state_q    <= state_d;
            ptr_q      <= ptr_d;
            bad_q      <= bad_d;
            tx_ready_q <= tx_ready_d;
            gmii_q     <= gmii_d;
            if (crc_clear) begin
                crc_q <= eth_pkg::CRC_INIT;
            end else if (crc_update) begin
                crc_q <= crc_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/eth_crc32_byte.sv
// one byte step of the reflected Ethernet CRC-32, purely combinational
// data bits are consumed lsb first, as they appear on the wire
`timescale 1ns/1ns
`default_nettype none

module eth_crc32_byte (
    input  wire logic [7:0]  data_in,
    input  wire logic [31:0] crc_state,
    output logic      [31:0] crc_next
);

    // intermediate remainder after each data bit
    logic [31:0] stage_0;
    logic [31:0] stage_1;
    logic [31:0] stage_2;
    logic [31:0] stage_3;
    logic [31:0] stage_4;
    logic [31:0] stage_5;
    logic [31:0] stage_6;
    logic [31:0] stage_7;

    // shift right, fold in the polynomial when the outgoing bit differs from the data bit
    function automatic logic [31:0] crc_bit(input logic [31:0] crc, input logic data_bit);
        logic feedback;
        feedback = crc[0] ^ data_bit;
        return (crc >> 1) ^ (feedback ? eth_pkg::CRC_POLY : 32'h0);
    endfunction

    always_comb begin
        stage_0  = crc_bit(crc_state, data_in[0]);
        stage_1  = crc_bit(stage_0, data_in[1]);
        stage_2  = crc_bit(stage_1, data_in[2]);
        stage_3  = crc_bit(stage_2, data_in[3]);
        stage_4  = crc_bit(stage_3, data_in[4]);
        stage_5  = crc_bit(stage_4, data_in[5]);
        stage_6  = crc_bit(stage_5, data_in[6]);
        stage_7  = crc_bit(stage_6, data_in[7]);
        crc_next = stage_7;
    end

endmodule

`default_nettype wire

// File: source/eth_pkg.sv
// shared types and Ethernet framing constants for the transmit path
// a stream beat is one byte; user is only meaningful on the last beat
`default_nettype none

package eth_pkg;

    // one byte of a transmit frame on the host, queue and MAC streams
    typedef struct packed {
        logic [7:0] data;
        // final byte of the frame
        logic       last;
        // on the last beat, marks the frame as bad
        logic       user;
    } tx_beat_t;

    // GMII transmit side, registered in the MAC
    typedef struct packed {
        logic [7:0] txd;
        logic       tx_en;
        logic       tx_er;
    } gmii_tx_t;

    // framing bytes
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // reflected CRC-32, shifted out lsb first
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

endpackage

`default_nettype wire
